// File: hdl/ap_pkg.sv
package ap_pkg;

    // Instruction field widths, MSB first: opcode, array address, operand 2, memory address
    localparam int OPCODE_W   = 4;
    localparam int CAM_ADDR_W = 8;                 // Row or column index into an array
    localparam int OPRAND2_W  = 2;                 // Array selector
    localparam int MEM_ADDR_W = 16;
    localparam int ISA_W      = OPCODE_W + CAM_ADDR_W + OPRAND2_W + MEM_ADDR_W;

    // Bit positions of the fields inside one instruction
    localparam int MEM_LSB = 0;
    localparam int OPR_LSB = MEM_LSB + MEM_ADDR_W;
    localparam int CAM_LSB = OPR_LSB + OPRAND2_W;
    localparam int OPC_LSB = CAM_LSB + CAM_ADDR_W;

    // Defaults handed down from the top level
    localparam int DATA_WIDTH_DEF = 8;
    localparam int DATA_DEPTH_DEF = 16;            // Twice the width, a column is two words
    localparam int ISA_DEPTH_DEF  = 132;
    localparam int DMEM_DEPTH_DEF = 256;           // Indexed by low memory address bits

    // Opcodes, code 3 is unused
    typedef enum logic [OPCODE_W-1:0] {
        RESET    = 4'd1,   // Clear A, B and R
        RET      = 4'd2,   // End of program
        LOADRBR  = 4'd4,   // Load one row
        LOADCBC  = 4'd5,   // Load one bit column from a word pair
        STORERBR = 4'd6,
        STORECBC = 4'd7,
        COPY     = 4'd8,
        ADD      = 4'd9,
        SUB      = 4'd10,
        TSC      = 4'd11,  // Two's complement negate
        ABS      = 4'd12
    } opcode_e;

    // Array selector in the operand 2 field
    typedef enum logic [OPRAND2_W-1:0] {
        NONE = 2'd0,
        M_A  = 2'd1,
        M_B  = 2'd2,
        M_R  = 2'd3
    } array_sel_e;

    typedef logic [ISA_W-1:0]      instr_t;
    typedef logic [CAM_ADDR_W-1:0] cam_addr_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

// File: hdl/ap_fetch.sv
`timescale 1ns/10ps

module ap_fetch import ap_pkg::*; #(
    parameter int ISA_DEPTH = 132
) (
    input  logic                         sys_clk_i,
    input  logic                         rst_n_i,
    input  logic                         start_i,     // One-cycle run pulse
    input  logic                         prog_we_i,   // Host program write
    input  logic [$clog2(ISA_DEPTH)-1:0] prog_addr_i,
    input  instr_t                       prog_data_i,
    input  logic                         stall_i,     // Hold PC and fetched word
    input  logic                         halt_i,      // RET seen in decode
    output instr_t                       f_instr_o,
    output logic                         f_valid_o
);

    localparam int PC_W = $clog2(ISA_DEPTH);

    instr_t            imem [ISA_DEPTH];   // Instruction memory
    logic   [PC_W-1:0] pc;                 // Address of next word to fetch
    logic              running;
    logic              fetch_en;

    // Advance only while running and not held by decode
    assign fetch_en = running && !stall_i && !start_i && !halt_i;

    // Host loads the program while the core is idle
    always_ff @(posedge sys_clk_i) begin
        if (prog_we_i) imem[prog_addr_i] <= prog_data_i;
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc        <= '0;
            running   <= 1'b0;
            f_valid_o <= 1'b0;
        end else if (start_i) begin   // New run from address 0
            pc        <= '0;
            running   <= 1'b1;
            f_valid_o <= 1'b0;
        end else if (halt_i) begin    // Stops for good until next start
            running   <= 1'b0;
            f_valid_o <= 1'b0;
        end else if (fetch_en) begin
            pc        <= pc + 1'b1;
            f_valid_o <= 1'b1;
        end
    end

    // Fetched word stays put on a stall
    always_ff @(posedge sys_clk_i) begin
        if (fetch_en) f_instr_o <= imem[pc];
    end

endmodule

// File: hdl/ap_decode.sv
`timescale 1ns/10ps

module ap_decode import ap_pkg::*; (
    input  logic       sys_clk_i,
    input  logic       rst_n_i,
    input  logic       start_i,
    input  instr_t     f_instr_i,
    input  logic       f_valid_i,
    output logic       stall_o,      // Load waits for an older store
    output logic       halt_o,       // RET accepted, no more fetching
    output logic       d_valid_o,
    output opcode_e    d_opcode_o,
    output cam_addr_t  d_cam_addr_o,
    output array_sel_e d_sel_o,
    output mem_addr_t  d_mem_addr_o
);

    opcode_e f_opcode;
    logic    f_is_load;
    logic    f_take;        // Instruction moves into decode this cycle
    logic    st_in_dec;     // Store in the decoded register
    logic    st_in_opr;     // Same store one stage later

    assign f_opcode  = opcode_e'(f_instr_i[OPC_LSB +: OPCODE_W]);
    assign f_is_load = (f_opcode == LOADRBR) || (f_opcode == LOADCBC);

    assign st_in_dec = d_valid_o && ((d_opcode_o == STORERBR) || (d_opcode_o == STORECBC));

    // A store writes memory three edges after it leaves decode
    // so a load behind it waits until its read comes after that write
    assign stall_o = f_valid_i && !halt_o && f_is_load && (st_in_dec || st_in_opr);

    // Words fetched after RET are dropped here
    assign f_take = f_valid_i && !halt_o && !stall_o;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            d_valid_o <= 1'b0;
            halt_o    <= 1'b0;
            st_in_opr <= 1'b0;
        end else if (start_i) begin   // Fresh run
            d_valid_o <= 1'b0;
            halt_o    <= 1'b0;
            st_in_opr <= 1'b0;
        end else begin
            d_valid_o <= f_take;       // Bubble on stall
            halt_o    <= halt_o || (f_take && (f_opcode == RET));
            st_in_opr <= st_in_dec;
        end
    end

    // Field split, held while nothing new comes in
    always_ff @(posedge sys_clk_i) begin
        if (f_take) begin
            d_opcode_o   <= f_opcode;
            d_cam_addr_o <= f_instr_i[CAM_LSB +: CAM_ADDR_W];
            d_sel_o      <= array_sel_e'(f_instr_i[OPR_LSB +: OPRAND2_W]);
            d_mem_addr_o <= f_instr_i[MEM_LSB +: MEM_ADDR_W];
        end
    end

endmodule

// File: hdl/ap_data_mem.sv
`timescale 1ns/10ps

module ap_data_mem import ap_pkg::*; #(
    parameter int DATA_WIDTH = 8,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                  sys_clk_i,
    input  logic                  rst_n_i,
    // Host port, core idle
    input  logic                  host_we_i,
    input  mem_addr_t             host_addr_i,
    input  logic [DATA_WIDTH-1:0] host_wdata_i,
    output logic [DATA_WIDTH-1:0] host_rdata_o,   // One cycle after address
    // Pair read for loads
    input  logic                  rd_req_i,
    input  mem_addr_t             rd_addr_i,
    output logic [DATA_WIDTH-1:0] rd_word0_o,     // Word at address
    output logic [DATA_WIDTH-1:0] rd_word1_o,     // Word at address plus one
    // Store port from the array
    input  logic                  st_we_i,
    input  logic                  st_pair_i,      // Column store writes two words
    input  mem_addr_t             st_addr_i,
    input  logic [DATA_WIDTH-1:0] st_word0_i,
    input  logic [DATA_WIDTH-1:0] st_word1_i
);

    localparam int AW = $clog2(DMEM_DEPTH);

    logic [DATA_WIDTH-1:0] mem [DMEM_DEPTH];

    logic [AW-1:0] host_idx;
    logic [AW-1:0] rd_idx0;
    logic [AW-1:0] rd_idx1;
    logic [AW-1:0] st_idx0;
    logic [AW-1:0] st_idx1;

    // Low address bits only, the pair wraps at the top
    assign host_idx = host_addr_i[AW-1:0];
    assign rd_idx0  = rd_addr_i[AW-1:0];
    assign rd_idx1  = rd_idx0 + 1'b1;
    assign st_idx0  = st_addr_i[AW-1:0];
    assign st_idx1  = st_idx0 + 1'b1;

    // Writes, the host and the core never overlap
    always_ff @(posedge sys_clk_i) begin
        if (host_we_i) begin
            mem[host_idx] <= host_wdata_i;
        end
        if (st_we_i) begin
            mem[st_idx0] <= st_word0_i;
            if (st_pair_i) mem[st_idx1] <= st_word1_i;   // High half of the column
        end
    end

    // Registered reads, old data on a same-edge write
    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_word0_o   <= '0;
            rd_word1_o   <= '0;
            host_rdata_o <= '0;
        end else begin
            if (rd_req_i) begin
                rd_word0_o <= mem[rd_idx0];
                rd_word1_o <= mem[rd_idx1];
            end
            host_rdata_o <= mem[host_idx];   // Free-running host read
        end
    end

endmodule

// File: hdl/ap_array.sv
`timescale 1ns/10ps

module ap_array import ap_pkg::*; #(
    parameter int DATA_WIDTH = 8,
    parameter int DATA_DEPTH = 16    // Must be 2 * DATA_WIDTH
) (
    input  logic                  sys_clk_i,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  d_valid_i,
    input  opcode_e               d_opcode_i,
    input  cam_addr_t             d_cam_addr_i,
    input  array_sel_e            d_sel_i,
    input  mem_addr_t             d_mem_addr_i,
    input  logic [DATA_WIDTH-1:0] rd_word0_i,
    input  logic [DATA_WIDTH-1:0] rd_word1_i,
    output logic                  st_we_o,
    output logic                  st_pair_o,
    output mem_addr_t             st_addr_o,
    output logic [DATA_WIDTH-1:0] st_word0_o,
    output logic [DATA_WIDTH-1:0] st_word1_o,
    output logic                  done_o
);

    localparam int ROW_W = $clog2(DATA_DEPTH);
    localparam int COL_W = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] arr [1:3][DATA_DEPTH];   // A, B, R by selector code

    // Operand-read stage, lines up with the memory read data
    logic       e_valid;
    opcode_e    e_opcode;
    cam_addr_t  e_cam_addr;
    array_sel_e e_sel;
    mem_addr_t  e_mem_addr;

    logic [ROW_W-1:0]      row_idx;
    logic [COL_W-1:0]      col_idx;
    array_sel_e            cp_src;     // COPY source from low address bits
    logic [DATA_WIDTH-1:0] sel_row;
    logic [DATA_WIDTH-1:0] col_lo;     // Rows 0 to W-1 of a column
    logic [DATA_WIDTH-1:0] col_hi;     // Rows W to 2W-1
    logic                  ret_exec;   // RET went through execute

    assign row_idx = e_cam_addr[ROW_W-1:0];
    assign col_idx = e_cam_addr[COL_W-1:0];
    assign cp_src  = array_sel_e'(e_cam_addr[1:0]);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            e_valid  <= 1'b0;
            ret_exec <= 1'b0;
            done_o   <= 1'b0;
            st_we_o  <= 1'b0;
        end else if (start_i) begin
            e_valid  <= 1'b0;
            ret_exec <= 1'b0;
            done_o   <= 1'b0;
            st_we_o  <= 1'b0;
        end else begin
            e_valid  <= d_valid_i;
            ret_exec <= e_valid && (e_opcode == RET);
            done_o   <= done_o || ret_exec;   // Last store has landed by now
            st_we_o  <= e_valid && (e_sel != NONE) &&
                        ((e_opcode == STORERBR) || (e_opcode == STORECBC));
        end
    end

    always_ff @(posedge sys_clk_i) begin
        e_opcode   <= d_opcode_i;
        e_cam_addr <= d_cam_addr_i;
        e_sel      <= d_sel_i;
        e_mem_addr <= d_mem_addr_i;
    end

    // Row and column views of the selected array
    always_comb begin
        sel_row = '0;
        col_lo  = '0;
        col_hi  = '0;
        if (e_sel != NONE) begin
            sel_row = arr[e_sel][row_idx];
            for (int r = 0; r < DATA_WIDTH; r++) begin
                col_lo[r] = arr[e_sel][r][col_idx];
                col_hi[r] = arr[e_sel][r + DATA_WIDTH][col_idx];
            end
        end
    end

    // Store data, written to memory on the next edge
    always_ff @(posedge sys_clk_i) begin
        st_pair_o  <= (e_opcode == STORECBC);
        st_addr_o  <= e_mem_addr;
        st_word0_o <= (e_opcode == STORECBC) ? col_lo : sel_row;
        st_word1_o <= col_hi;
    end

    // Execute, every row in the same cycle
    always_ff @(posedge sys_clk_i) begin
        if (e_valid) begin
            case (e_opcode)
                RESET: begin
                    for (int r = 0; r < DATA_DEPTH; r++) begin
                        arr[M_A][r] <= '0;
                        arr[M_B][r] <= '0;
                        arr[M_R][r] <= '0;
                    end
                end
                LOADRBR: begin
                    if (e_sel != NONE) arr[e_sel][row_idx] <= rd_word0_i;
                end
                LOADCBC: begin
                    if (e_sel != NONE) begin
                        for (int r = 0; r < DATA_WIDTH; r++) begin
                            arr[e_sel][r][col_idx]              <= rd_word0_i[r];
                            arr[e_sel][r + DATA_WIDTH][col_idx] <= rd_word1_i[r];
                        end
                    end
                end
                COPY: begin   // Destination is operand 2
                    if ((e_sel != NONE) && (cp_src != NONE)) begin
                        for (int r = 0; r < DATA_DEPTH; r++) arr[e_sel][r] <= arr[cp_src][r];
                    end
                end
                ADD: begin
                    for (int r = 0; r < DATA_DEPTH; r++) arr[M_R][r] <= arr[M_A][r] + arr[M_B][r];
                end
                SUB: begin
                    for (int r = 0; r < DATA_DEPTH; r++) arr[M_R][r] <= arr[M_A][r] - arr[M_B][r];
                end
                TSC: begin
                    for (int r = 0; r < DATA_DEPTH; r++) arr[M_R][r] <= -arr[M_A][r];
                end
                ABS: begin    // Most negative value wraps onto itself
                    for (int r = 0; r < DATA_DEPTH; r++) begin
                        arr[M_R][r] <= arr[M_A][r][DATA_WIDTH-1] ? -arr[M_A][r] : arr[M_A][r];
                    end
                end
                default: ;    // RET and stores leave the arrays alone
            endcase
        end
    end

endmodule

// File: hdl/ap_top.sv
`timescale 1ns/10ps

module ap_top import ap_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int DATA_DEPTH = DATA_DEPTH_DEF,
    parameter int ISA_DEPTH  = ISA_DEPTH_DEF,
    parameter int DMEM_DEPTH = DMEM_DEPTH_DEF
) (
    input  logic                         sys_clk_i,
    input  logic                         rst_n_i,
    input  logic                         start_i,
    input  logic                         prog_we_i,
    input  logic [$clog2(ISA_DEPTH)-1:0] prog_addr_i,
    input  instr_t                       prog_data_i,
    input  logic                         host_we_i,
    input  mem_addr_t                    host_addr_i,
    input  logic [DATA_WIDTH-1:0]        host_wdata_i,
    output logic [DATA_WIDTH-1:0]        host_rdata_o,
    output logic                         done_o
);

    // Fetch to decode
    instr_t                f_instr;
    logic                  f_valid;
    logic                  stall;
    logic                  halt;
    // Decode to memory and array
    logic                  d_valid;
    opcode_e               d_opcode;
    cam_addr_t             d_cam_addr;
    array_sel_e            d_sel;
    mem_addr_t             d_mem_addr;
    // Memory and array
    logic [DATA_WIDTH-1:0] rd_word0;
    logic [DATA_WIDTH-1:0] rd_word1;
    logic                  st_we;
    logic                  st_pair;
    mem_addr_t             st_addr;
    logic [DATA_WIDTH-1:0] st_word0;
    logic [DATA_WIDTH-1:0] st_word1;

    ap_fetch #(.ISA_DEPTH(ISA_DEPTH)) fetch0 (
        .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i), .start_i(start_i),
        .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
        .stall_i(stall), .halt_i(halt), .f_instr_o(f_instr), .f_valid_o(f_valid)
    );

    ap_decode decode0 (
        .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i), .start_i(start_i),
        .f_instr_i(f_instr), .f_valid_i(f_valid), .stall_o(stall), .halt_o(halt),
        .d_valid_o(d_valid), .d_opcode_o(d_opcode), .d_cam_addr_o(d_cam_addr),
        .d_sel_o(d_sel), .d_mem_addr_o(d_mem_addr)
    );

    // Every decoded word reads its pair, only loads use it
    ap_data_mem #(.DATA_WIDTH(DATA_WIDTH), .DMEM_DEPTH(DMEM_DEPTH)) dmem0 (
        .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i),
        .host_we_i(host_we_i), .host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
        .host_rdata_o(host_rdata_o), .rd_req_i(d_valid), .rd_addr_i(d_mem_addr),
        .rd_word0_o(rd_word0), .rd_word1_o(rd_word1), .st_we_i(st_we), .st_pair_i(st_pair),
        .st_addr_i(st_addr), .st_word0_i(st_word0), .st_word1_i(st_word1)
    );

    ap_array #(.DATA_WIDTH(DATA_WIDTH), .DATA_DEPTH(DATA_DEPTH)) array0 (
        .sys_clk_i(sys_clk_i), .rst_n_i(rst_n_i), .start_i(start_i),
        .d_valid_i(d_valid), .d_opcode_i(d_opcode), .d_cam_addr_i(d_cam_addr),
        .d_sel_i(d_sel), .d_mem_addr_i(d_mem_addr),
        .rd_word0_i(rd_word0), .rd_word1_i(rd_word1),
        .st_we_o(st_we), .st_pair_o(st_pair), .st_addr_o(st_addr),
        .st_word0_o(st_word0), .st_word1_o(st_word1), .done_o(done_o)
    );

endmodule

// File: verif/ap_clk_gen.sv
`timescale 1ns/10ps

module ap_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
) (
    output logic sys_clk_o,
    output logic rst_n_o
);

    initial begin
        sys_clk_o = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk_o = ~sys_clk_o;
    end

    // Released on a rising edge after the hold time
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge sys_clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// File: verif/ap_tb.sv
`timescale 1ns/10ps

module ap_tb import ap_pkg::*; ();

    typedef logic [DATA_WIDTH_DEF-1:0] word_t;

    localparam int PROG_SUM    = 4 + 33 + 101 + 33 + 83 + 5;   // Instructions run over all tests
    localparam int MARGIN_CYC  = 2000;                         // Host loads and readback
    localparam int WATCHDOG_NS = (PROG_SUM * 4 + MARGIN_CYC) * 40;

    logic                             sys_clk;
    logic                             rst_n;
    logic                             start;
    logic                             prog_we;
    logic [$clog2(ISA_DEPTH_DEF)-1:0] prog_addr;
    instr_t                           prog_data;
    logic                             host_we;
    mem_addr_t                        host_addr;
    word_t                            host_wdata;
    word_t                            host_rdata;
    logic                             done;

    instr_t prog_q[$];   // Program under construction
    word_t  a_w[16];
    word_t  b_w[16];
    word_t  exp_w[16];
    word_t  col_w[8][2]; // Word pair per column
    int     err_cnt  = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     test_err0;

    ap_clk_gen clk0 (.sys_clk_o(sys_clk), .rst_n_o(rst_n));

    ap_top dut0 (
        .sys_clk_i(sys_clk), .rst_n_i(rst_n), .start_i(start),
        .prog_we_i(prog_we), .prog_addr_i(prog_addr), .prog_data_i(prog_data),
        .host_we_i(host_we), .host_addr_i(host_addr), .host_wdata_i(host_wdata),
        .host_rdata_o(host_rdata), .done_o(done)
    );

    // Field order opcode, array address, operand 2, memory address
    function automatic instr_t encode(opcode_e op, int cam, array_sel_e sel, int addr);
        encode = {op, cam[CAM_ADDR_W-1:0], sel, addr[MEM_ADDR_W-1:0]};
    endfunction

    function automatic word_t negate(word_t x);
        negate = ~x + 1'b1;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAIL %0t ns %s expected 0x%02h got 0x%02h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_done(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0t ns %s expected %b got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic write_word(input int addr, input word_t data);
        @(posedge sys_clk);
        host_we    <= 1'b1;
        host_addr  <= addr[MEM_ADDR_W-1:0];
        host_wdata <= data;
        @(posedge sys_clk);
        host_we    <= 1'b0;
    endtask

    // Registered read is stable one edge after the address
    task automatic read_word(input int addr, output word_t data);
        @(posedge sys_clk);
        host_addr <= addr[MEM_ADDR_W-1:0];
        @(posedge sys_clk);
        @(negedge sys_clk);
        data = host_rdata;
    endtask

    task automatic check_block(input int base);
        word_t got;
        for (int i = 0; i < 16; i++) begin
            read_word(base + i, got);
            check_word($sformatf("host_rdata_o[0x%02h]", base + i), exp_w[i], got);
        end
    endtask

    task automatic load_prog();
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge sys_clk);
            prog_we   <= 1'b1;
            prog_addr <= i[$clog2(ISA_DEPTH_DEF)-1:0];
            prog_data <= prog_q[i];
        end
        @(posedge sys_clk);
        prog_we <= 1'b0;
    endtask

    task automatic start_pulse();
        @(posedge sys_clk);
        start <= 1'b1;
        @(posedge sys_clk);
        start <= 1'b0;
        @(negedge sys_clk);
    endtask

    task automatic wait_done(input int n_instr);
        int cyc;
        cyc = 0;
        while (done !== 1'b1 && cyc < n_instr * 4 + 20) begin
            @(negedge sys_clk);
            cyc++;
        end
        if (done !== 1'b1) begin
            $display("Program of %0d instructions did not finish in %0d cycles", n_instr, cyc);
            err_cnt++;
        end
    endtask

    task automatic run_prog();
        load_prog();
        start_pulse();
        wait_done(prog_q.size());
        prog_q.delete();
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err0) begin
            pass_cnt++;
            $display("%s: passed", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d mismatches", name, err_cnt - test_err0);
        end
    endtask

    task automatic reset_done_test();
        test_err0 = err_cnt;
        check_done("done_o after reset", 1'b0, done);
        prog_q.push_back(encode(RESET, 0, NONE, 0));
        prog_q.push_back(encode(RET, 0, NONE, 0));
        load_prog();
        start_pulse();
        wait_done(2);
        check_done("done_o after RET", 1'b1, done);
        start_pulse();                             // Same program again
        check_done("done_o after start", 1'b0, done);
        wait_done(2);
        prog_q.delete();
        end_test("reset_done");
    endtask

    task automatic row_trip_test();
        test_err0 = err_cnt;
        for (int r = 0; r < 16; r++) begin
            a_w[r] = word_t'($urandom);
            write_word(8'h00 + r, a_w[r]);
            prog_q.push_back(encode(LOADRBR, r, M_A, 8'h00 + r));
        end
        for (int r = 0; r < 16; r++) prog_q.push_back(encode(STORERBR, r, M_A, 8'h20 + r));
        prog_q.push_back(encode(RET, 0, NONE, 0));
        run_prog();
        exp_w = a_w;
        check_block(8'h20);
        end_test("row_round_trip");
    endtask

    task automatic arith_test();
        opcode_e ops[4];
        int      sv;
        test_err0 = err_cnt;
        ops = '{ADD, SUB, TSC, ABS};
        for (int r = 0; r < 16; r++) begin
            a_w[r] = word_t'($urandom);
            b_w[r] = word_t'($urandom);
        end
        a_w[0] = 8'h80;   // Edge values with the most negative and zero
        b_w[0] = 8'h00;
        a_w[1] = 8'h00;
        b_w[1] = 8'h80;
        a_w[2] = 8'h7f;
        b_w[2] = 8'h01;
        for (int r = 0; r < 16; r++) begin
            write_word(8'h40 + r, a_w[r]);
            write_word(8'h50 + r, b_w[r]);
            prog_q.push_back(encode(LOADRBR, r, M_A, 8'h40 + r));
            prog_q.push_back(encode(LOADRBR, r, M_B, 8'h50 + r));
        end
        foreach (ops[k]) begin
            prog_q.push_back(encode(ops[k], 0, NONE, 0));
            for (int r = 0; r < 16; r++) begin
                prog_q.push_back(encode(STORERBR, r, M_R, 8'h60 + 16 * k + r));
            end
        end
        prog_q.push_back(encode(RET, 0, NONE, 0));
        run_prog();
        for (int r = 0; r < 16; r++) exp_w[r] = a_w[r] + b_w[r];
        check_block(8'h60);
        for (int r = 0; r < 16; r++) exp_w[r] = a_w[r] - b_w[r];
        check_block(8'h70);
        for (int r = 0; r < 16; r++) exp_w[r] = negate(a_w[r]);
        check_block(8'h80);
        // Magnitude of the signed word taken modulo 2^8
        for (int r = 0; r < 16; r++) begin
            sv       = $signed(a_w[r]);
            exp_w[r] = word_t'((sv < 0) ? -sv : sv);
        end
        check_block(8'h90);
        end_test("arithmetic");
    endtask

    task automatic column_test();
        word_t got;
        test_err0 = err_cnt;
        for (int c = 0; c < 8; c++) begin
            for (int h = 0; h < 2; h++) begin
                col_w[c][h] = word_t'($urandom);
                write_word(8'ha0 + 2 * c + h, col_w[c][h]);
            end
            prog_q.push_back(encode(LOADCBC, c, M_B, 8'ha0 + 2 * c));
        end
        for (int r = 0; r < 16; r++) prog_q.push_back(encode(STORERBR, r, M_B, 8'hc0 + r));
        for (int c = 0; c < 8; c++) prog_q.push_back(encode(STORECBC, c, M_B, 8'he0 + 2 * c));
        prog_q.push_back(encode(RET, 0, NONE, 0));
        run_prog();
        // Row r bit c comes from bit r mod 8 of word r div 8 of pair c
        for (int r = 0; r < 16; r++) begin
            for (int c = 0; c < 8; c++) exp_w[r][c] = col_w[c][r / 8][r % 8];
        end
        check_block(8'hc0);
        for (int c = 0; c < 8; c++) begin
            for (int h = 0; h < 2; h++) begin
                read_word(8'he0 + 2 * c + h, got);
                check_word($sformatf("host_rdata_o[0x%02h]", 8'he0 + 2 * c + h),
                           col_w[c][h], got);
            end
        end
        end_test("column_transfer");
    endtask

    task automatic copy_reset_test();
        test_err0 = err_cnt;
        for (int r = 0; r < 16; r++) begin
            a_w[r] = word_t'($urandom);
            write_word(8'h00 + r, a_w[r]);
            prog_q.push_back(encode(LOADRBR, r, M_A, 8'h00 + r));
        end
        for (int i = 8'h60; i < 8'h90; i++) write_word(i, word_t'(i ^ 8'h5a));   // Nonzero fill
        prog_q.push_back(encode(COPY, M_A, M_B, 0));   // Source in the array address field
        for (int r = 0; r < 16; r++) prog_q.push_back(encode(STORERBR, r, M_B, 8'h30 + r));
        prog_q.push_back(encode(RESET, 0, NONE, 0));
        for (int r = 0; r < 16; r++) begin
            prog_q.push_back(encode(STORERBR, r, M_A, 8'h60 + r));
            prog_q.push_back(encode(STORERBR, r, M_B, 8'h70 + r));
            prog_q.push_back(encode(STORERBR, r, M_R, 8'h80 + r));
        end
        prog_q.push_back(encode(RET, 0, NONE, 0));
        run_prog();
        exp_w = a_w;
        check_block(8'h30);
        exp_w = '{default: '0};
        check_block(8'h60);
        check_block(8'h70);
        check_block(8'h80);
        end_test("copy_reset");
    endtask

    task automatic load_after_store_test();
        word_t v;
        word_t got;
        test_err0 = err_cnt;
        v = word_t'($urandom);
        write_word(8'h10, v);
        write_word(8'h18, ~v);   // Stale value a missing interlock would read
        prog_q.push_back(encode(LOADRBR, 3, M_A, 8'h10));
        prog_q.push_back(encode(STORERBR, 3, M_A, 8'h18));
        prog_q.push_back(encode(LOADRBR, 5, M_R, 8'h18));
        prog_q.push_back(encode(STORERBR, 5, M_R, 8'h19));
        prog_q.push_back(encode(RET, 0, NONE, 0));
        run_prog();
        read_word(8'h18, got);
        check_word("host_rdata_o[0x18]", v, got);
        read_word(8'h19, got);
        check_word("host_rdata_o[0x19]", v, got);
        end_test("load_after_store");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        start      = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        void'($urandom(83043));
        @(posedge rst_n);
        @(negedge sys_clk);
        reset_done_test();
        row_trip_test();
        arith_test();
        column_test();
        copy_reset_test();
        load_after_store_test();
        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
hdl/ap_pkg.sv
hdl/ap_fetch.sv
hdl/ap_decode.sv
hdl/ap_data_mem.sv
hdl/ap_array.sv
hdl/ap_top.sv
verif/ap_clk_gen.sv
verif/ap_tb.sv
